// File: filelist.f
+incdir+test
rtl/rf_read_pkg.sv
rtl/prf_int_data.sv
rtl/operand_select.sv
rtl/prf_int.sv
test/prf_int_tb.sv

// File: rtl/operand_select.sv
// ~~~~~~~~~~~~~~~~~~~~
// Operand selection for each way. Steers register indices to storage and
// picks each operand from the register word or the micro-op's own fields.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module operand_select #(
  parameter int prf_ways = rf_read_pkg::prf_ways_default
) (
  input  wire  rf_read_pkg::micro_op_t [prf_ways-1:0]          uop_in,
  input  wire  [prf_ways-1:0][rf_read_pkg::xlen-1:0]           rs1_raw,
  input  wire  [prf_ways-1:0][rf_read_pkg::xlen-1:0]           rs2_raw,
  output logic [prf_ways-1:0][rf_read_pkg::prf_index_bits-1:0] rs1_index,
  output logic [prf_ways-1:0][rf_read_pkg::prf_index_bits-1:0] rs2_index,
  output logic [prf_ways-1:0][rf_read_pkg::xlen-1:0]           rs1_operand,
  output logic [prf_ways-1:0][rf_read_pkg::xlen-1:0]           rs2_operand
);

  import rf_read_pkg::*;

  // Non-register sources park the read port on index zero
  function automatic logic [prf_index_bits-1:0] pick_index(
    input rs_source_t                source,
    input logic [prf_index_bits-1:0] field
  );
    return (source == rs_from_rf) ? field : '0;
  endfunction

  function automatic logic [xlen-1:0] pick_operand(
    input micro_op_t       uop,
    input rs_source_t      source,
    input logic [xlen-1:0] raw
  );
    logic [xlen-1:0] value;
    case (source)
      rs_from_rf:   value = raw;
      rs_from_imm:  value = uop.imm;
      rs_from_pc:   value = uop.pc;
      rs_from_npc:  value = uop.npc;
      rs_from_zero: value = '0;
      rs_invalid:   value = '0;
      default:      value = '0;  // Unused codes
    endcase
    return value;
  endfunction

  always_comb begin
    for (int i = 0; i < prf_ways; i++) begin
      rs1_index[i]   = pick_index(uop_in[i].rs1_source, uop_in[i].prf_rs1_index);
      rs2_index[i]   = pick_index(uop_in[i].rs2_source, uop_in[i].prf_rs2_index);
      rs1_operand[i] = pick_operand(uop_in[i], uop_in[i].rs1_source, rs1_raw[i]);
      rs2_operand[i] = pick_operand(uop_in[i], uop_in[i].rs2_source, rs2_raw[i]);
    end
  end

  // Decode upstream must only emit defined source codes
  always_comb begin
    for (int i = 0; i < prf_ways; i++) begin
      if (uop_in[i].valid) begin
        assert (uop_in[i].rs1_source inside {rs_invalid, rs_from_rf, rs_from_imm,
                                             rs_from_zero, rs_from_pc, rs_from_npc})
          else $error("way %0d rs1_source code %0d undefined", i, uop_in[i].rs1_source);
        assert (uop_in[i].rs2_source inside {rs_invalid, rs_from_rf, rs_from_imm,
                                             rs_from_zero, rs_from_pc, rs_from_npc})
          else $error("way %0d rs2_source code %0d undefined", i, uop_in[i].rs2_source);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/prf_int.sv
// ~~~~~~~~~~~~~~~~~~~~
// Integer register-read stage. Reads operands for every way each cycle and
// hands micro-ops with their operands to execute one cycle later.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module prf_int #(
  parameter int prf_ways = rf_read_pkg::prf_ways_default,
  parameter int prf_size = rf_read_pkg::prf_size_default
) (
  input  wire                                        clock,
  input  wire                                        reset,
  input  wire  rf_read_pkg::micro_op_t [prf_ways-1:0] uop_in,
  input  wire  rf_read_pkg::prf_write_t [prf_ways-1:0] wb,
  output rf_read_pkg::micro_op_t [prf_ways-1:0]       uop_out,
  output logic [prf_ways-1:0][rf_read_pkg::xlen-1:0]  rs1_data,
  output logic [prf_ways-1:0][rf_read_pkg::xlen-1:0]  rs2_data
);

  import rf_read_pkg::*;

  logic [prf_ways-1:0][prf_index_bits-1:0] rs1_index;
  logic [prf_ways-1:0][prf_index_bits-1:0] rs2_index;
  logic [prf_ways-1:0][xlen-1:0]           rs1_raw;      // Storage plus bypass
  logic [prf_ways-1:0][xlen-1:0]           rs2_raw;
  logic [prf_ways-1:0][xlen-1:0]           rs1_operand;  // After source select
  logic [prf_ways-1:0][xlen-1:0]           rs2_operand;

  // ~~~~~~~~~~~~~~~~~~~~
  // Read path
  // ~~~~~~~~~~~~~~~~~~~~

  operand_select #(
    .prf_ways    (prf_ways)
  ) operand_select_inst (
    .uop_in      (uop_in),
    .rs1_raw     (rs1_raw),
    .rs2_raw     (rs2_raw),
    .rs1_index   (rs1_index),
    .rs2_index   (rs2_index),
    .rs1_operand (rs1_operand),
    .rs2_operand (rs2_operand)
  );

  prf_int_data #(
    .prf_ways  (prf_ways),
    .prf_size  (prf_size)
  ) prf_int_data_inst (
    .clock     (clock),
    .reset     (reset),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .wb        (wb),
    .rs1_raw   (rs1_raw),
    .rs2_raw   (rs2_raw)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Output register to execute
  // ~~~~~~~~~~~~~~~~~~~~

  // Loaded every cycle, no stall
  always_ff @(posedge clock) begin
    for (int i = 0; i < prf_ways; i++) begin
      uop_out[i] <= uop_in[i];
      if (reset) begin
        uop_out[i].valid <= 1'b0;
        rs1_data[i]      <= '0;
        rs2_data[i]      <= '0;
      end else begin
        rs1_data[i] <= rs1_operand[i];
        rs2_data[i] <= rs2_operand[i];
      end
    end
  end

  // Execute must not see a stale micro-op in the first cycle out of reset
  generate
    for (genvar i = 0; i < prf_ways; i++) begin : g_reset_check
      assert property (
        @(posedge clock) $fell(reset) |-> !uop_out[i].valid
      ) else $error("uop_out[%0d] valid right after reset", i);
    end
  endgenerate

endmodule

`default_nettype wire

// File: rtl/prf_int_data.sv
// ~~~~~~~~~~~~~~~~~~~~
// Physical integer register storage with two read ports and one write port
// per way. Reads are combinational and see same-cycle writes.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module prf_int_data #(
  parameter int prf_ways = rf_read_pkg::prf_ways_default,
  parameter int prf_size = rf_read_pkg::prf_size_default
) (
  input  wire                                                  clock,
  input  wire                                                  reset,
  input  wire  [prf_ways-1:0][rf_read_pkg::prf_index_bits-1:0] rs1_index,
  input  wire  [prf_ways-1:0][rf_read_pkg::prf_index_bits-1:0] rs2_index,
  input  wire  rf_read_pkg::prf_write_t [prf_ways-1:0]         wb,
  output logic [prf_ways-1:0][rf_read_pkg::xlen-1:0]           rs1_raw,
  output logic [prf_ways-1:0][rf_read_pkg::xlen-1:0]           rs2_raw
);

  import rf_read_pkg::*;

  logic [xlen-1:0] rf [prf_size];

  // ~~~~~~~~~~~~~~~~~~~~
  // Write ports
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < prf_size; k++) begin
        rf[k] <= '0;
      end
    end else begin
      for (int j = 0; j < prf_ways; j++) begin
        if (wb[j].en) begin
          rf[wb[j].index] <= wb[j].data;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Read ports
  // ~~~~~~~~~~~~~~~~~~~~

  // Stored word, replaced by a matching write in flight this cycle
  function automatic logic [xlen-1:0] read_word(input logic [prf_index_bits-1:0] index);
    logic [xlen-1:0] word;
    word = rf[index];
    for (int j = 0; j < prf_ways; j++) begin
      if (wb[j].en && (wb[j].index == index)) begin
        word = wb[j].data;  // At most one port can match
      end
    end
    return word;
  endfunction

  always_comb begin
    for (int i = 0; i < prf_ways; i++) begin
      rs1_raw[i] = read_word(rs1_index[i]);
      rs2_raw[i] = read_word(rs2_index[i]);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Write port checks
  // ~~~~~~~~~~~~~~~~~~~~

  generate
    for (genvar a = 0; a < prf_ways; a++) begin : g_wb_check
      assert property (
        @(posedge clock) disable iff (reset)
        wb[a].en |-> (wb[a].index < prf_size)
      ) else $error("wb[%0d] index %0d out of range", a, wb[a].index);

      // Writeback network must never target one register twice
      for (genvar b = a + 1; b < prf_ways; b++) begin : g_pair
        assert property (
          @(posedge clock) disable iff (reset)
          !(wb[a].en && wb[b].en && (wb[a].index == wb[b].index))
        ) else $error("wb[%0d] and wb[%0d] both write index %0d", a, b, wb[a].index);
      end
    end
  endgenerate

endmodule

`default_nettype wire

// File: rtl/rf_read_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types and sizes for the integer register-read stage.
// Import inside each module body that needs the micro-op or writeback types.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rf_read_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Sizes
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int prf_ways_default = 2;   // Parallel read/write ways
  localparam int prf_size_default = 64;  // Physical integer registers

  // Index width follows the default register count
  localparam int prf_index_bits = $clog2(prf_size_default);

  localparam int xlen     = 32;  // Data word
  localparam int tag_bits = 8;   // Opaque micro-op identifier

  // ~~~~~~~~~~~~~~~~~~~~
  // Operand source
  // ~~~~~~~~~~~~~~~~~~~~

  // Codes 6 and 7 are unused
  typedef enum logic [2:0] {
    rs_invalid   = 3'd0,
    rs_from_rf   = 3'd1,  // Physical register file
    rs_from_imm  = 3'd2,  // Decoded immediate
    rs_from_zero = 3'd3,
    rs_from_pc   = 3'd4,
    rs_from_npc  = 3'd5   // Next PC, for link values
  } rs_source_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Micro-op
  // ~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic                      valid;
    rs_source_t                rs1_source;
    rs_source_t                rs2_source;
    logic [prf_index_bits-1:0] prf_rs1_index;
    logic [prf_index_bits-1:0] prf_rs2_index;
    logic [prf_index_bits-1:0] prf_rd_index;  // Destination, used by execute
    logic [xlen-1:0]           imm;
    logic [xlen-1:0]           pc;
    logic [xlen-1:0]           npc;
    logic [tag_bits-1:0]       tag;           // Passed through untouched
  } micro_op_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Writeback port
  // ~~~~~~~~~~~~~~~~~~~~

  // One per way, strobed for a single cycle
  typedef struct packed {
    logic                      en;
    logic [prf_index_bits-1:0] index;
    logic [xlen-1:0]           data;
  } prf_write_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the register-read testbench with Verilator, runs it and checks the log.
# Returns nonzero when the build or the run fails or the log reports failure.

set -u

cd "$(dirname "$0")" || exit 1

build_dir="build"
log_file="sim.log"

verilator --binary -sv --assert -Wno-fatal \
  --top-module prf_int_tb \
  -Mdir "$build_dir" \
  -f filelist.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$build_dir/Vprf_int_tb" 2>&1 | tee "$log_file"
run_status=${PIPESTATUS[0]}
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if [ ! -s "$log_file" ]; then
  echo "Simulation log is empty"
  exit 1
fi

if grep -q "TEST FAILED" "$log_file"; then
  echo "Simulation reported failures, see $log_file"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: test/prf_int_vectors.svh
// ~~~~~~~~~~~~~~~~~~~~
// Directed stimulus table for the register-read testbench, one row per cycle.
// Included inside the testbench module after the package import.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef prf_int_vectors_svh
`define prf_int_vectors_svh

// Columns per lane: write en, write index, write data,
// then uop valid, rs1 source, rs2 source, rs1 index, rs2 index, tag,
// expected rs1, expected rs2. Expected tag and valid equal the applied ones.
// imm, pc and npc are 32'h1100_0000, 32'h2200_0000, 32'h3300_0000 ORed with the tag

typedef struct packed {
  prf_write_t                wr;
  logic                      valid;
  rs_source_t                rs1_source;
  rs_source_t                rs2_source;
  logic [prf_index_bits-1:0] rs1_index;
  logic [prf_index_bits-1:0] rs2_index;
  logic [tag_bits-1:0]       tag;
  logic [xlen-1:0]           exp_rs1;
  logic [xlen-1:0]           exp_rs2;
} lane_t;

localparam int num_rows = 9;

lane_t vec [num_rows][prf_ways_default];

function automatic lane_t lane(
  input logic en, input logic [prf_index_bits-1:0] windex, input logic [xlen-1:0] wdata,
  input logic valid, input rs_source_t s1, input rs_source_t s2,
  input logic [prf_index_bits-1:0] i1, input logic [prf_index_bits-1:0] i2,
  input logic [tag_bits-1:0] tag, input logic [xlen-1:0] e1, input logic [xlen-1:0] e2
);
  return '{wr: '{en: en, index: windex, data: wdata}, valid: valid, rs1_source: s1,
           rs2_source: s2, rs1_index: i1, rs2_index: i2, tag: tag, exp_rs1: e1, exp_rs2: e2};
endfunction

task automatic load_table();
  // Reset state, every register reads zero
  vec[0][0] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_rf, rs_from_rf, 6'd5, 6'd6, 8'h01, 32'h0, 32'h0);
  vec[0][1] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_rf, rs_from_rf, 6'd63, 6'd1, 8'h02, 32'h0, 32'h0);
  // Writes land, zero and invalid sources ignore them
  vec[1][0] = lane(1'b1, 6'd5, 32'hdead_0005,
    1'b0, rs_from_zero, rs_from_zero, 6'd5, 6'd6, 8'h03, 32'h0, 32'h0);
  vec[1][1] = lane(1'b1, 6'd6, 32'hbeef_0006,
    1'b0, rs_invalid, rs_invalid, 6'd6, 6'd5, 8'h04, 32'h0, 32'h0);
  // Read back on both ways
  vec[2][0] = lane(1'b1, 6'd10, 32'h1234_000a,
    1'b1, rs_from_rf, rs_from_rf, 6'd5, 6'd6, 8'h05, 32'hdead_0005, 32'hbeef_0006);
  vec[2][1] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_rf, rs_from_rf, 6'd6, 6'd5, 8'h06, 32'hbeef_0006, 32'hdead_0005);
  // Bypass within a way and across ways
  vec[3][0] = lane(1'b1, 6'd20, 32'h0000_aa14,
    1'b1, rs_from_rf, rs_from_rf, 6'd20, 6'd21, 8'h07, 32'h0000_aa14, 32'h0000_bb15);
  vec[3][1] = lane(1'b1, 6'd21, 32'h0000_bb15,
    1'b1, rs_from_rf, rs_from_rf, 6'd21, 6'd20, 8'h08, 32'h0000_bb15, 32'h0000_aa14);
  vec[4][0] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_rf, rs_from_rf, 6'd20, 6'd10, 8'h09, 32'h0000_aa14, 32'h1234_000a);
  vec[4][1] = lane(1'b1, 6'd5, 32'h5555_0005,
    1'b1, rs_from_rf, rs_from_rf, 6'd21, 6'd5, 8'h0a, 32'h0000_bb15, 32'h5555_0005);
  // Non-register sources
  vec[5][0] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_imm, rs_from_pc, 6'd20, 6'd21, 8'h0b, 32'h1100_000b, 32'h2200_000b);
  vec[5][1] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_npc, rs_from_zero, 6'd5, 6'd20, 8'h0c, 32'h3300_000c, 32'h0);
  vec[6][0] = lane(1'b1, 6'd5, 32'h6666_0005,
    1'b1, rs_invalid, rs_from_npc, 6'd5, 6'd10, 8'h0d, 32'h0, 32'h3300_000d);
  vec[6][1] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_pc, rs_from_imm, 6'd6, 6'd21, 8'h0e, 32'h2200_000e, 32'h1100_000e);
  vec[7][0] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_rf, rs_from_rf, 6'd5, 6'd6, 8'h0f, 32'h6666_0005, 32'hbeef_0006);
  vec[7][1] = lane(1'b1, 6'd63, 32'hffff_003f,
    1'b1, rs_from_rf, rs_from_rf, 6'd63, 6'd0, 8'h10, 32'hffff_003f, 32'h0);
  vec[8][0] = lane(1'b0, 6'd0, 32'h0,
    1'b0, rs_from_rf, rs_from_rf, 6'd63, 6'd10, 8'h11, 32'hffff_003f, 32'h1234_000a);
  vec[8][1] = lane(1'b0, 6'd0, 32'h0,
    1'b1, rs_from_zero, rs_from_imm, 6'd21, 6'd0, 8'h12, 32'h0, 32'h1100_0012);
endtask

`endif

// File: test/prf_int_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the integer register-read stage. Runs the directed table,
// then a seeded random phase checked against a register model.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module prf_int_tb;

  import rf_read_pkg::*;

  localparam int ways          = prf_ways_default;
  localparam int regs          = prf_size_default;
  localparam int random_cycles = 200;

  logic                      clock;
  logic                      reset;
  micro_op_t  [ways-1:0]     uop_in;
  prf_write_t [ways-1:0]     wb;
  micro_op_t  [ways-1:0]     uop_out;
  logic [ways-1:0][xlen-1:0] rs1_data;
  logic [ways-1:0][xlen-1:0] rs2_data;

  `include "prf_int_vectors.svh"

  localparam int cycle_limit = num_rows + random_cycles + 50;

  logic [xlen-1:0]     model_rf [regs];  // Register contents as the DUT should hold them
  logic [xlen-1:0]     exp_rs1 [ways];
  logic [xlen-1:0]     exp_rs2 [ways];
  logic [tag_bits-1:0] exp_tag [ways];
  logic                exp_valid [ways];
  micro_op_t           exp_uop [ways];  // Whole micro-op as execute should see it
  int error_count;
  int tests_passed;
  int tests_failed;
  int cycle_count;

  prf_int prf_int_inst (
    .clock    (clock),
    .reset    (reset),
    .uop_in   (uop_in),
    .wb       (wb),
    .uop_out  (uop_out),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Run stopped after %0d cycles without reaching the end", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic [xlen-1:0] expected_operand(
    input micro_op_t                 uop,
    input rs_source_t                source,
    input logic [prf_index_bits-1:0] index,
    input prf_write_t [ways-1:0]     writes
  );
    logic [xlen-1:0] stored;
    stored = model_rf[index];
    for (int j = 0; j < ways; j++) begin
      if (writes[j].en && (writes[j].index == index)) begin
        stored = writes[j].data;  // Written this very cycle
      end
    end
    if (source == rs_from_rf) return stored;
    if (source == rs_from_imm) return uop.imm;
    if (source == rs_from_pc) return uop.pc;
    if (source == rs_from_npc) return uop.npc;
    return '0;
  endfunction

  task automatic apply_cycle(input micro_op_t [ways-1:0] uops,
                             input prf_write_t [ways-1:0] writes);
    for (int w = 0; w < ways; w++) begin
      exp_rs1[w] = expected_operand(uops[w], uops[w].rs1_source, uops[w].prf_rs1_index, writes);
      exp_rs2[w] = expected_operand(uops[w], uops[w].rs2_source, uops[w].prf_rs2_index, writes);
      exp_tag[w]   = uops[w].tag;
      exp_valid[w] = uops[w].valid;
      exp_uop[w]   = uops[w];
    end
    for (int j = 0; j < ways; j++) begin
      if (writes[j].en) model_rf[writes[j].index] = writes[j].data;
    end
    uop_in = uops;
    wb     = writes;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic mismatch(input string name, input logic [xlen-1:0] expected,
                          input logic [xlen-1:0] actual);
    $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic check_outputs();
    for (int w = 0; w < ways; w++) begin
      if (uop_out[w].valid !== exp_valid[w])
        mismatch($sformatf("uop_out[%0d].valid", w), 32'(exp_valid[w]), 32'(uop_out[w].valid));
      if (uop_out[w].tag !== exp_tag[w])
        mismatch($sformatf("uop_out[%0d].tag", w), 32'(exp_tag[w]), 32'(uop_out[w].tag));
      if (uop_out[w] !== exp_uop[w]) begin
        $display("CHECK FAILED at %0t: uop_out[%0d] expected %h got %h",
                 $time, w, exp_uop[w], uop_out[w]);
        error_count++;
      end
      if (rs1_data[w] !== exp_rs1[w])
        mismatch($sformatf("rs1_data[%0d]", w), exp_rs1[w], rs1_data[w]);
      if (rs2_data[w] !== exp_rs2[w])
        mismatch($sformatf("rs2_data[%0d]", w), exp_rs2[w], rs2_data[w]);
    end
  endtask

  task automatic finish_test(input string name, input int fails);
    if (fails == 0) begin
      $display("%s: passed", name);
      tests_passed++;
    end else begin
      $display("%s: failed with %0d mismatches", name, fails);
      tests_failed++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic micro_op_t table_uop(input lane_t l);
    micro_op_t uop;
    uop               = '0;
    uop.valid         = l.valid;
    uop.rs1_source    = l.rs1_source;
    uop.rs2_source    = l.rs2_source;
    uop.prf_rs1_index = l.rs1_index;
    uop.prf_rs2_index = l.rs2_index;
    uop.tag           = l.tag;
    uop.imm           = 32'h1100_0000 | 32'(l.tag);
    uop.pc            = 32'h2200_0000 | 32'(l.tag);
    uop.npc           = 32'h3300_0000 | 32'(l.tag);
    return uop;
  endfunction

  // Indices kept low so reuse and bypass hits are frequent
  function automatic micro_op_t random_uop(input logic [tag_bits-1:0] tag);
    micro_op_t uop;
    uop.valid         = 1'($urandom);
    uop.rs1_source    = rs_source_t'(3'($urandom_range(5, 0)));
    uop.rs2_source    = rs_source_t'(3'($urandom_range(5, 0)));
    uop.prf_rs1_index = prf_index_bits'($urandom_range(15, 0));
    uop.prf_rs2_index = prf_index_bits'($urandom_range(15, 0));
    uop.prf_rd_index  = prf_index_bits'($urandom);
    uop.imm           = $urandom;
    uop.pc            = $urandom;
    uop.npc           = $urandom;
    uop.tag           = tag;
    return uop;
  endfunction

  initial begin
    micro_op_t  [ways-1:0] uops;
    prf_write_t [ways-1:0] writes;
    int start_errors;
    void'($urandom(32'hc5da));
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count  = 0;
    reset  = 1'b1;
    uop_in = '0;
    wb     = '0;
    for (int k = 0; k < regs; k++) model_rf[k] = '0;
    load_table();

    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    start_errors = error_count;
    for (int w = 0; w < ways; w++) begin
      exp_valid[w] = 1'b0;
      exp_tag[w]   = '0;  // Output register took the idle input during reset
      exp_uop[w]   = '0;
      exp_rs1[w]   = '0;
      exp_rs2[w]   = '0;
    end
    check_outputs();
    finish_test("reset state", error_count - start_errors);

    for (int r = 0; r < num_rows; r++) begin
      for (int w = 0; w < ways; w++) begin
        uops[w]   = table_uop(vec[r][w]);
        writes[w] = vec[r][w].wr;
      end
      apply_cycle(uops, writes);
      for (int w = 0; w < ways; w++) begin
        exp_rs1[w] = vec[r][w].exp_rs1;  // Operands worked out by hand in the table
        exp_rs2[w] = vec[r][w].exp_rs2;
      end
      @(negedge clock);
      start_errors = error_count;
      check_outputs();
      finish_test($sformatf("table row %0d", r), error_count - start_errors);
    end

    start_errors = error_count;
    for (int c = 0; c < random_cycles; c++) begin
      for (int w = 0; w < ways; w++) begin
        uops[w]         = random_uop(tag_bits'(c));
        writes[w].en    = 1'($urandom);
        writes[w].index = prf_index_bits'($urandom_range(15, 0));
        writes[w].data  = $urandom;
      end
      // Two ports never write one register in the same cycle
      for (int j = 1; j < ways; j++) begin
        for (int k = 0; k < j; k++) begin
          if (writes[j].en && writes[k].en && (writes[j].index == writes[k].index))
            writes[j].en = 1'b0;
        end
      end
      apply_cycle(uops, writes);
      @(negedge clock);
      check_outputs();
    end
    finish_test("random mix", error_count - start_errors);

    $display("Tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
